// ==== Makefile ====
# Verilator build and run for the vote accumulator

VERILATOR  ?= verilator
TOP        ?= vote_unit_tb
RTL_TOP    ?= vote_unit
FILELIST   ?= vote_unit.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --timescale $(TIMESCALE) -j 0
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
PASS_MSG   ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/vote_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_accumulator #(
    parameter int N_LANES = 16,
    parameter int ACC_W   = 30
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire vote_pkg::vote_t [N_LANES-1:0]  votes,
    input  wire                                 store_any,
    input  wire                                 clear,
    output vote_pkg::acc_t                      total,
    output logic                                sign_bit
);

    import vote_pkg::*;

    // groups of GROUP_LANES, last one padded with zero votes
    localparam int N_GROUPS = (N_LANES + GROUP_LANES - 1) / GROUP_LANES;
    localparam int N_PAD    = N_GROUPS * GROUP_LANES;

    vote_t                   votes_pad [N_PAD];
    part_t                   part_next [N_GROUPS];
    part_t                   part_q    [N_GROUPS];
    logic                    store_d1;
    logic                    store_d2;
    acc_t                    tree_sum;
    logic signed [ACC_W-1:0] total_q;

    // pad the lane vector up to a whole number of groups
    for (genvar i = 0; i < N_PAD; i++) begin : g_pad
        if (i < N_LANES) begin : g_lane
            assign votes_pad[i] = votes[i];
        end else begin : g_zero
            assign votes_pad[i] = '0;
        end
    end

    // first tree level, one partial sum per group
    always_comb begin
        for (int g = 0; g < N_GROUPS; g++) begin
            part_next[g] = '0;
            for (int l = 0; l < GROUP_LANES; l++) begin
                // size cast keeps the sign of the vote
                part_next[g] = part_next[g] + part_t'(votes_pad[g*GROUP_LANES + l]);
            end
        end
    end

    // partial sums land one edge after the votes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int g = 0; g < N_GROUPS; g++) begin
                part_q[g] <= '0;
            end
        end else begin
            for (int g = 0; g < N_GROUPS; g++) begin
                part_q[g] <= part_next[g];
            end
        end
    end

    // store strobe follows the data through two stages
    // d1 lines up with the votes, d2 with the partial sums
    always_ff @(posedge clk) begin
        if (rst) begin
            store_d1 <= 1'b0;
            store_d2 <= 1'b0;
        end else begin
            store_d1 <= store_any;
            store_d2 <= store_d1;
        end
    end

    // second tree level, all partial sums together
    always_comb begin
        tree_sum = '0;
        for (int g = 0; g < N_GROUPS; g++) begin
            tree_sum = tree_sum + acc_t'(part_q[g]);
        end
    end

    // running total, wraps at ACC_W bits
    // clear beats an add landing on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            total_q <= '0;
        end else if (clear) begin
            total_q <= '0;
        end else if (store_d2) begin
            total_q <= total_q + tree_sum[ACC_W-1:0];
        end
    end

    // widen to the shared total type
    assign total    = acc_t'(total_q);
    // sign of the vote count
    assign sign_bit = total_q[ACC_W-1];

endmodule

`default_nettype wire

// ==== hdl/vote_pkg.sv ====
`default_nettype none

package vote_pkg;

    // one lane vote: -1, 0 or +1
    typedef logic signed [1:0] vote_t;

    // lanes summed into one partial sum
    localparam int GROUP_LANES = 4;

    // partial sum of one group
    // range is +/- GROUP_LANES, fits 4 bits signed
    typedef logic signed [3:0] part_t;

    // widest total the top level may ask for
    localparam int ACC_W_MAX = 32;

    // running total as seen outside the accumulator
    // narrower totals are sign-extended into this
    typedef logic signed [ACC_W_MAX-1:0] acc_t;

endpackage

`default_nettype wire

// ==== hdl/vote_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_regs #(
    parameter int N_LANES = 16
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             reg_wr,
    input  wire vote_regs_pkg::reg_addr_t   reg_addr,
    input  wire vote_regs_pkg::reg_data_t   reg_wdata,
    output vote_regs_pkg::reg_data_t        reg_rdata,
    input  wire vote_pkg::acc_t             total,
    output logic [N_LANES-1:0]              lane_mask,
    output logic                            clear
);

    import vote_regs_pkg::*;

    logic wr_mask;
    logic wr_clear;

    // write decode
    assign wr_mask  = reg_wr && (reg_addr == ADDR_MASK);
    assign wr_clear = reg_wr && (reg_addr == ADDR_CTRL) && reg_wdata[CTRL_CLEAR_BIT];

    // lane mask, all lanes enabled out of reset
    // only the implemented lanes are stored
    always_ff @(posedge clk) begin
        if (rst) begin
            lane_mask <= '1;
        end else if (wr_mask) begin
            lane_mask <= reg_wdata[N_LANES-1:0];
        end
    end

    // clear is a one cycle pulse after the ctrl write
    // bit is not sticky, nothing to read back
    always_ff @(posedge clk) begin
        if (rst) begin
            clear <= 1'b0;
        end else begin
            clear <= wr_clear;
        end
    end

    // read-back mux, straight from the address
    always_comb begin
        case (reg_addr)
            ADDR_MASK: begin
                // unused upper lanes read as zero
                reg_rdata = reg_data_t'(lane_mask);
            end
            ADDR_TOTAL: begin
                // total arrives already sign-extended
                reg_rdata = reg_data_t'(total);
            end
            default: begin
                // ctrl and the spare address
                reg_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/vote_regs_pkg.sv ====
`default_nettype none

package vote_regs_pkg;

    // register address and data word
    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // lane enable mask, read/write
    localparam reg_addr_t ADDR_MASK  = 2'd0;
    // control, write only
    localparam reg_addr_t ADDR_CTRL  = 2'd1;
    // running total, read only, sign-extended
    localparam reg_addr_t ADDR_TOTAL = 2'd2;

    // ctrl word: clear request
    localparam int CTRL_CLEAR_BIT = 0;

endpackage

`default_nettype wire

// ==== hdl/vote_selector.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_selector (
    input  wire             clk,
    input  wire             rst,
    input  wire             store_bit,
    input  wire             result_bit,
    input  wire             lane_en,
    output vote_pkg::vote_t vote
);

    import vote_pkg::*;

    vote_t vote_next;

    // map store and result onto a signed vote
    // a masked or idle lane votes zero
    always_comb begin
        vote_next = '0;
        if (store_bit && lane_en) begin
            if (result_bit) begin
                vote_next = 2'sd1;
            end else begin
                vote_next = -2'sd1;
            end
        end
    end

    // one register stage per lane
    always_ff @(posedge clk) begin
        if (rst) begin
            vote <= '0;
        end else begin
            vote <= vote_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vote_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_unit #(
    parameter int N_LANES = 16,
    parameter int ACC_W   = 30
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire [N_LANES-1:0]               store,
    input  wire [N_LANES-1:0]               core_result,
    input  wire                             reg_wr,
    input  wire vote_regs_pkg::reg_addr_t   reg_addr,
    input  wire vote_regs_pkg::reg_data_t   reg_wdata,
    output wire vote_regs_pkg::reg_data_t   reg_rdata,
    output wire vote_pkg::acc_t             total,
    output wire                             sign_bit
);

    import vote_pkg::*;

    // one vote per lane into the tree
    vote_t [N_LANES-1:0] votes;
    logic  [N_LANES-1:0] lane_mask;
    logic                clear;
    logic                store_any;

    // any lane storing this cycle
    assign store_any = |store;

    // mask and clear come from software
    vote_regs #(
        .N_LANES (N_LANES)
    ) u_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .total     (total),
        .lane_mask (lane_mask),
        .clear     (clear)
    );

    // per lane vote conversion
    for (genvar k = 0; k < N_LANES; k++) begin : g_lane
        vote_selector u_sel (
            .clk        (clk),
            .rst        (rst),
            .store_bit  (store[k]),
            .result_bit (core_result[k]),
            .lane_en    (lane_mask[k]),
            .vote       (votes[k])
        );
    end

    // tree, strobe delay and running total
    vote_accumulator #(
        .N_LANES (N_LANES),
        .ACC_W   (ACC_W)
    ) u_acc (
        .clk       (clk),
        .rst       (rst),
        .votes     (votes),
        .store_any (store_any),
        .clear     (clear),
        .total     (total),
        .sign_bit  (sign_bit)
    );

endmodule

`default_nettype wire

// ==== verification/vote_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module vote_unit_tb;

    import vote_pkg::*;
    import vote_regs_pkg::*;

    localparam int N_LANES = 16;

    logic                clk = 1'b0;
    logic                rst;
    logic [N_LANES-1:0]  store;
    logic [N_LANES-1:0]  core_result;
    logic                reg_wr;
    reg_addr_t           reg_addr;
    reg_data_t           reg_wdata;
    reg_data_t           reg_rdata;
    acc_t                total;
    logic                sign_bit;

    // parsed vector file, one entry per command line
    byte                 cmd_q[$];
    logic [8*32-1:0]     name_q[$];
    logic [31:0]         a_q[$];
    logic [31:0]         b_q[$];

    // edges since the last store sample and the last register write
    int                  since_store = 8;
    int                  since_wr = 8;

    int unsigned         cycle_count = 0;
    int unsigned         cycle_limit = 32'hffff_ffff;

    vote_unit uut (
        .clk         (clk),
        .rst         (rst),
        .store       (store),
        .core_result (core_result),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .total       (total),
        .sign_bit    (sign_bit)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "run stopped at first failure");
    endtask

    // run limit, scaled from the vector count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run went past %0d clock cycles", cycle_limit);
            stop_on_error();
        end
    end

    task automatic check_total(input string test, input acc_t exp_val, input acc_t act_val);
        if (act_val !== exp_val) begin
            $display("ERR %s: total expected %h, actual %h", test, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_sign(input string test, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("ERR %s: sign expected %b, actual %b", test, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_rdata(input string test, input reg_data_t exp_val,
                               input reg_data_t act_val);
        if (act_val !== exp_val) begin
            $display("ERR %s: rdata expected %h, actual %h", test, exp_val, act_val);
            stop_on_error();
        end
    endtask

    // read every command line up front
    task automatic load_vectors();
        int               fd;
        int               n_fields;
        logic [8*128-1:0] line_bits;
        logic [7:0]       cmd;
        logic [8*32-1:0]  name_bits;
        logic [31:0]      arg_a;
        logic [31:0]      arg_b;
        fd = $fopen("verification/vote_unit_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            stop_on_error();
        end
        line_bits = '0;
        while ($fgets(line_bits, fd) != 0) begin
            cmd = 8'h00;
            name_bits = '0;
            arg_a = '0;
            arg_b = '0;
            n_fields = $sscanf(line_bits, "%s %s %h %h", cmd, name_bits, arg_a, arg_b);
            // skip blank and comment lines
            if (n_fields >= 2 && cmd != "#") begin
                cmd_q.push_back(cmd);
                name_q.push_back(name_bits);
                a_q.push_back(arg_a);
                b_q.push_back(arg_b);
            end
            line_bits = '0;
        end
        $fclose(fd);
        cycle_limit = cmd_q.size() * 8 + 50;
    endtask

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
        since_store++;
        since_wr++;
    endtask

    // idle until stores and writes have reached the total
    task automatic settle();
        while (since_store < 2 || since_wr < 1) begin
            next_cycle();
        end
    endtask

    task automatic do_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        next_cycle();
        since_wr = 0;
        reg_wr = 1'b0;
        reg_wdata = '0;
    endtask

    task automatic do_store(input logic [N_LANES-1:0] st, input logic [N_LANES-1:0] res);
        logic [N_LANES-1:0] noise;
        // idle lanes get random results
        noise = N_LANES'($urandom);
        store = st;
        core_result = (res & st) | (noise & ~st);
        next_cycle();
        since_store = 0;
        store = '0;
        core_result = N_LANES'($urandom);
    endtask

    task automatic do_check(input string test, input acc_t exp_total, input logic exp_sign);
        settle();
        check_total(test, exp_total, total);
        check_sign(test, exp_sign, sign_bit);
    endtask

    task automatic do_read(input string test, input reg_addr_t addr, input reg_data_t exp_val);
        settle();
        reg_addr = addr;
        // combinational read path
        #1;
        check_rdata(test, exp_val, reg_rdata);
        // back onto the drive point after the next edge
        next_cycle();
    endtask

    task automatic run_command(input int idx);
        string       test;
        logic [31:0] a;
        logic [31:0] b;
        test = $sformatf("%0s", name_q[idx]);
        a = a_q[idx];
        b = b_q[idx];
        case (cmd_q[idx])
            "W": do_write(a[1:0], b);
            "S": do_store(a[N_LANES-1:0], b[N_LANES-1:0]);
            "I": begin
                repeat (a) next_cycle();
            end
            "C": do_check(test, acc_t'(a), b[0]);
            "R": do_read(test, a[1:0], b);
            default: begin
                $display("unknown command %c on test %s", cmd_q[idx], test);
                stop_on_error();
            end
        endcase
    endtask

    initial begin
        void'($urandom(28));
        rst = 1'b1;
        store = '0;
        core_result = '0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        load_vectors();
        // reset for 4 cycles
        repeat (4) next_cycle();
        rst = 1'b0;
        for (int i = 0; i < cmd_q.size(); i++) begin
            run_command(i);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/vote_unit_vectors.txt ====
# cmd name arg_a arg_b, args in hex
# W addr data | S store result | I cycles | C total sign | R addr rdata
C reset_total 00000000 0
R reset_mask 0 0000ffff
R reset_total_rd 2 00000000
R reset_ctrl_rd 1 00000000
R reset_spare_rd 3 00000000
S all_set ffff ffff
C all_set 00000010 0
S ten_six ffff 03ff
C ten_six 00000014 0
S mostly_clear ffff 0000
C mostly_clear 00000004 0
S neg_step ffff 0001
C neg_step fffffff6 1
R neg_readback 2 fffffff6
S b2b_a 00ff 00ff
S b2b_b f000 7000
S b2b_c 0f0f 0f0f
S b2b_d 0003 0000
S b2b_e 8000 8000
C b2b_sum 00000007 0
W mask_wr 0 000000ff
R mask_rd 0 000000ff
S masked ffff ffff
S masked_out ff00 0000
C masked 0000000f 0
W mask_wide 0 ffff0f0f
R mask_wide_rd 0 00000f0f
S mask_mix ffff 0000
C mask_mix 00000007 0
W mask_all 0 0000ffff
W clear_wr 1 00000001
C after_clear 00000000 0
R after_clear_rd 2 00000000
S post_clear ffff ffff
C post_clear 00000010 0
W ctrl_noclear 1 00000002
C ctrl_noclear 00000010 0
R ctrl_rd 1 00000000
S race_a 000f 000f
W race_clear 1 00000001
C race_lost 00000000 0
W clear_again 1 00000001
S after_edge 00ff 0000
C after_edge fffffff8 1
R after_edge_rd 2 fffffff8
I idle 4
C idle_hold fffffff8 1

// ==== vote_unit.f ====
hdl/vote_pkg.sv
hdl/vote_regs_pkg.sv
hdl/vote_selector.sv
hdl/vote_accumulator.sv
hdl/vote_regs.sv
hdl/vote_unit.sv
verification/vote_unit_tb.sv
